/* hw/busDecode.sv */
/*
	Register bus decode
	Chip select, one-hot write and read strobes, idle cycle and data drive enable
*/
`timescale 1ns/100ps
`default_nettype none

module busDecode import viaPkg::*; #(
	parameter int DATA_W = 8
) (
	input  wire               clk,
	input  wire               nRESET,
	input  wire               clkEn,
	input  wire               cs1,
	input  wire               nCs2,
	input  wire               rnw,
	input  wire  [3:0]        rs,
	output logic [15:0]       wr,
	output logic [15:0]       rd,
	output logic              busIdle,
	output logic [DATA_W-1:0] dataOe
);

	logic   chipSel;
	logic   wrCycle;
	logic   rdCycle;
	regAddr sel;

	assign chipSel = cs1 & ~nCs2;
	assign wrCycle = clkEn & chipSel & ~rnw;
	assign rdCycle = clkEn & chipSel & rnw;
	assign sel     = regAddr'(rs);

	// One strobe per register select
	always_comb begin
		wr      = '0;
		rd      = '0;
		wr[sel] = wrCycle;
		rd[sel] = rdCycle;
	end

	// Interrupt events are accepted on bus cycles that miss the chip
	assign busIdle = clkEn & ~chipSel;

	// Data bus driven for a selected read while out of reset
	assign dataOe = {DATA_W{chipSel & rnw & nRESET}};

endmodule

`default_nettype wire

/* hw/edgeDetect.sv */
/*
	Two-stage input synchronizer with rise and fall pulse outputs
*/
`timescale 1ns/100ps
`default_nettype none

module edgeDetect #(
	parameter int LINE_N = 5
) (
	input  wire               clk,
	input  wire               nRESET,
	input  wire  [LINE_N-1:0] lines,
	output logic [LINE_N-1:0] rise,
	output logic [LINE_N-1:0] fall
);

	logic [LINE_N-1:0] sync1;
	logic [LINE_N-1:0] sync2;
	logic [LINE_N-1:0] prev;

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			// Preload every stage so leaving reset makes no edge
			sync1 <= lines;
			sync2 <= lines;
			prev  <= lines;
		end else begin
			sync1 <= lines;
			sync2 <= sync1;
			prev  <= sync2;
		end
	end

	assign rise = sync2 & ~prev;
	assign fall = ~sync2 & prev;

endmodule

`default_nettype wire

/* hw/interruptCtrl.sv */
/*
	Interrupt flag and enable registers
	Edge polarity select, event hold during accesses, flag clear rules, nIrq
*/
`timescale 1ns/100ps
`default_nettype none

module interruptCtrl import viaPkg::*; (
	input  wire        clk,
	input  wire        nRESET,
	input  wire [15:0] wr,
	input  wire [15:0] rd,
	input  wire        busIdle,
	input  wire [7:0]  dataIn,
	input  wire [7:0]  pcr,
	input  wire [4:0]  rise,
	input  wire [4:0]  fall,
	input  wire        t1Event,
	input  wire        t2Event,
	output logic [6:0] ifr,
	output logic [6:0] ier,
	output logic       nIrq
);

	logic [6:0] evNow;
	logic [6:0] pending;
	logic [6:0] clr;
	logic       oraAccess;
	logic       orbAccess;

	assign oraAccess = rd[regOra] | wr[regOra] | rd[regOraNh] | wr[regOraNh];
	assign orbAccess = rd[regOrb] | wr[regOrb];

	// Active edge per control line
	always_comb begin
		evNow          = '0;
		evNow[flagCa1] = pcr[pcrCa1Pos] ? rise[lineCa1] : fall[lineCa1];
		evNow[flagCa2] = pcr[pcrCa2Pos] ? rise[lineCa2] : fall[lineCa2];
		evNow[flagCb1] = pcr[pcrCb1Pos] ? rise[lineCb1] : fall[lineCb1];
		evNow[flagCb2] = pcr[pcrCb2Pos] ? rise[lineCb2] : fall[lineCb2];
		evNow[flagSr]  = 1'b0;
		evNow[flagT1]  = t1Event;
		evNow[flagT2]  = t2Event;
	end

	// Flags cleared by this access
	always_comb begin
		clr = '0;
		if (rd[regT1cl] | wr[regT1ch])
			clr[flagT1] = 1'b1;
		if (rd[regT2cl] | wr[regT2ch])
			clr[flagT2] = 1'b1;
		if (oraAccess) begin
			clr[flagCa1] = 1'b1;
			clr[flagCa2] = 1'b1;
		end
		if (orbAccess) begin
			clr[flagCb1] = 1'b1;
			clr[flagCb2] = 1'b1;
		end
		// Writing a one to an IFR bit clears it
		if (wr[regIfr])
			clr = clr | dataIn[6:0];
	end

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			ifr     <= '0;
			pending <= '0;
		end else if (busIdle) begin
			ifr     <= ifr | pending | evNow;
			pending <= '0;
		end else begin
			ifr     <= ifr & ~clr;
			pending <= pending | evNow;
		end
	end

	// Bit 7 of the written data picks set or clear
	always_ff @(posedge clk) begin
		if (!nRESET)
			ier <= '0;
		else if (wr[regIer])
			ier <= dataIn[7] ? (ier | dataIn[6:0]) : (ier & ~dataIn[6:0]);
	end

	assign nIrq = ~|(ifr & ier);

endmodule

`default_nettype wire

/* hw/intervalTimer1.sv */
/*
	Timer 1
	16-bit latch and down counter, one-shot and free-run modes, PB7 output
*/
`timescale 1ns/100ps
`default_nettype none

module intervalTimer1 import viaPkg::*; (
	input  wire         clk,
	input  wire         nRESET,
	input  wire         clkEn,
	input  wire  [15:0] wr,
	input  wire  [7:0]  dataIn,
	input  wire         freeRun,
	input  wire         pb7Mode,
	output logic [15:0] count,
	output logic [15:0] latch,
	output logic        t1Event,
	output logic        pb7
);

	logic armed;
	logic load;
	logic atZero;

	// Writing the counter high byte starts the timer
	assign load   = wr[regT1ch];
	assign atZero = (count == 16'd0);

	// One-shot mode fires once per load
	assign t1Event = clkEn & atZero & ~load & (freeRun | armed);

	// T1CL and T1LL both write the low latch byte
	always_ff @(posedge clk) begin
		if (!nRESET) begin
			latch <= '0;
		end else begin
			if (wr[regT1cl] | wr[regT1ll])
				latch[7:0] <= dataIn;
			if (wr[regT1lh] | wr[regT1ch])
				latch[15:8] <= dataIn;
		end
	end

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			count <= '0;
			armed <= 1'b0;
		end else if (load) begin
			count <= {dataIn, latch[7:0]};
			armed <= 1'b1;
		end else if (clkEn) begin
			// Reload at zero in both modes
			if (atZero)
				count <= latch;
			else
				count <= count - 16'd1;
			if (t1Event)
				armed <= 1'b0;
		end
	end

	// PB7 sits high while the timer does not own the pin
	always_ff @(posedge clk) begin
		if (!nRESET) begin
			pb7 <= 1'b1;
		end else if (!pb7Mode) begin
			pb7 <= 1'b1;
		end else if (load) begin
			pb7 <= 1'b0;
		end else if (t1Event) begin
			// Square wave in free run, single low pulse otherwise
			pb7 <= freeRun ? ~pb7 : 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/portOutput.sv */
/*
	Port A and B output and direction registers, ACR and PCR
	Pin drivers and the register read multiplexer
*/
`timescale 1ns/100ps
`default_nettype none

module portOutput import viaPkg::*; #(
	parameter int DATA_W = 8
) (
	input  wire               clk,
	input  wire               nRESET,
	input  wire  [15:0]       wr,
	input  wire  [DATA_W-1:0] dataIn,
	input  wire  [3:0]        rs,
	input  wire  [DATA_W-1:0] portAIn,
	input  wire  [DATA_W-1:0] portBIn,
	input  wire               pb7,
	input  wire               pb7Mode,
	input  wire  [15:0]       t1Count,
	input  wire  [15:0]       t1Latch,
	input  wire  [15:0]       t2Count,
	input  wire  [6:0]        ifr,
	input  wire  [6:0]        ier,
	input  wire               nIrq,
	output logic [DATA_W-1:0] portAOut,
	output logic [DATA_W-1:0] portAOe,
	output logic [DATA_W-1:0] portBOut,
	output logic [DATA_W-1:0] portBOe,
	output logic [DATA_W-1:0] acr,
	output logic [DATA_W-1:0] pcr,
	output logic [DATA_W-1:0] dataOut
);

	logic [DATA_W-1:0] ora;
	logic [DATA_W-1:0] orb;
	logic [DATA_W-1:0] ddra;
	logic [DATA_W-1:0] ddrb;
	logic [DATA_W-1:0] pinA;
	logic [DATA_W-1:0] pinB;

	always_ff @(posedge clk) begin
		if (wr[regOra] | wr[regOraNh])
			ora <= dataIn;
		if (wr[regOrb])
			orb <= dataIn;
	end

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			ddra <= '0;
			ddrb <= '0;
			acr  <= '0;
			pcr  <= '0;
		end else begin
			if (wr[regDdra])
				ddra <= dataIn;
			if (wr[regDdrb])
				ddrb <= dataIn;
			if (wr[regAcr])
				acr <= dataIn;
			if (wr[regPcr])
				pcr <= dataIn;
		end
	end

	// Timer 1 takes over PB7
	assign portAOut = ora;
	assign portAOe  = ddra;
	assign portBOut = {pb7Mode ? pb7 : orb[DATA_W-1], orb[DATA_W-2:0]};
	assign portBOe  = ddrb;

	// Pin value as seen by a read
	assign pinA = (portAOut & ddra) | (portAIn & ~ddra);
	assign pinB = (portBOut & ddrb) | (portBIn & ~ddrb);

	always_comb begin
		case (regAddr'(rs))
			regOrb:           dataOut = pinB;
			regOra, regOraNh: dataOut = pinA;
			regDdrb:          dataOut = ddrb;
			regDdra:          dataOut = ddra;
			regT1cl:          dataOut = t1Count[DATA_W-1:0];
			regT1ch:          dataOut = t1Count[2*DATA_W-1:DATA_W];
			regT1ll:          dataOut = t1Latch[DATA_W-1:0];
			regT1lh:          dataOut = t1Latch[2*DATA_W-1:DATA_W];
			regT2cl:          dataOut = t2Count[DATA_W-1:0];
			regT2ch:          dataOut = t2Count[2*DATA_W-1:DATA_W];
			regAcr:           dataOut = acr;
			regPcr:           dataOut = pcr;
			regIfr:           dataOut = {~nIrq, ifr};
			regIer:           dataOut = {1'b1, ier};
			// No shift register
			default:          dataOut = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hw/pulseTimer2.sv */
/*
	Timer 2
	16-bit down counter, one-shot on clkEn or counting PB6 falling edges
*/
`timescale 1ns/100ps
`default_nettype none

module pulseTimer2 import viaPkg::*; (
	input  wire         clk,
	input  wire         nRESET,
	input  wire         clkEn,
	input  wire  [15:0] wr,
	input  wire  [7:0]  dataIn,
	input  wire         countMode,
	input  wire         pb6Fall,
	output logic [15:0] count,
	output logic        t2Event
);

	logic [7:0] latchLo;
	logic       armed;
	logic       fallSeen;
	logic       load;
	logic       step;
	logic       hit;

	assign load = wr[regT2ch];

	// A PB6 edge between bus cycles waits for the next clkEn
	assign step = clkEn & (~countMode | pb6Fall | fallSeen);

	// Count mode fires as the counter reaches zero, one-shot when it reads zero
	assign hit     = countMode ? (count == 16'd1) : (count == 16'd0);
	assign t2Event = step & hit & armed & ~load;

	always_ff @(posedge clk) begin
		if (wr[regT2cl])
			latchLo <= dataIn;
	end

	always_ff @(posedge clk) begin
		if (!nRESET)
			fallSeen <= 1'b0;
		else if (clkEn)
			fallSeen <= 1'b0;
		else if (pb6Fall)
			fallSeen <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!nRESET) begin
			count <= '0;
			armed <= 1'b0;
		end else if (load) begin
			count <= {dataIn, latchLo};
			armed <= 1'b1;
		end else if (step) begin
			// No reload, the counter keeps rolling past zero
			count <= count - 16'd1;
			if (t2Event)
				armed <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hw/via6522.sv */
/*
	VIA top level
	Bus decode, edge detect, two timers, interrupt control and ports
*/
`timescale 1ns/100ps
`default_nettype none

module via6522 import viaPkg::*; #(
	parameter int DATA_W = 8
) (
	input  wire               clk,
	input  wire               nRESET,
	input  wire               clkEn,
	input  wire               cs1,
	input  wire               nCs2,
	input  wire               rnw,
	input  wire  [3:0]        rs,
	input  wire  [DATA_W-1:0] dataIn,
	input  wire               ca1,
	input  wire               ca2,
	input  wire               cb1,
	input  wire               cb2,
	input  wire  [DATA_W-1:0] portAIn,
	input  wire  [DATA_W-1:0] portBIn,
	output logic [DATA_W-1:0] dataOut,
	output logic [DATA_W-1:0] dataOe,
	output logic [DATA_W-1:0] portAOut,
	output logic [DATA_W-1:0] portAOe,
	output logic [DATA_W-1:0] portBOut,
	output logic [DATA_W-1:0] portBOe,
	output logic              nIrq
);

	logic [15:0]       wr;
	logic [15:0]       rd;
	logic              busIdle;
	logic [4:0]        rise;
	logic [4:0]        fall;
	logic [15:0]       t1Count;
	logic [15:0]       t1Latch;
	logic              t1Event;
	logic              pb7;
	logic [15:0]       t2Count;
	logic              t2Event;
	logic [6:0]        ifr;
	logic [6:0]        ier;
	logic [DATA_W-1:0] acr;
	logic [DATA_W-1:0] pcr;

	busDecode #(.DATA_W(DATA_W)) uBusDecode (
		.clk(clk), .nRESET(nRESET), .clkEn(clkEn),
		.cs1(cs1), .nCs2(nCs2), .rnw(rnw), .rs(rs),
		.wr(wr), .rd(rd), .busIdle(busIdle), .dataOe(dataOe)
	);

	// Line order follows the lineXxx indices
	edgeDetect #(.LINE_N(5)) uEdgeDetect (
		.clk(clk), .nRESET(nRESET),
		.lines({portBIn[6], cb2, cb1, ca2, ca1}),
		.rise(rise), .fall(fall)
	);

	intervalTimer1 uTimer1 (
		.clk(clk), .nRESET(nRESET), .clkEn(clkEn), .wr(wr), .dataIn(dataIn),
		.freeRun(acr[acrT1FreeRun]), .pb7Mode(acr[acrT1Pb7]),
		.count(t1Count), .latch(t1Latch), .t1Event(t1Event), .pb7(pb7)
	);

	pulseTimer2 uTimer2 (
		.clk(clk), .nRESET(nRESET), .clkEn(clkEn), .wr(wr), .dataIn(dataIn),
		.countMode(acr[acrT2Count]), .pb6Fall(fall[linePb6]),
		.count(t2Count), .t2Event(t2Event)
	);

	interruptCtrl uInterruptCtrl (
		.clk(clk), .nRESET(nRESET), .wr(wr), .rd(rd), .busIdle(busIdle),
		.dataIn(dataIn), .pcr(pcr), .rise(rise), .fall(fall),
		.t1Event(t1Event), .t2Event(t2Event),
		.ifr(ifr), .ier(ier), .nIrq(nIrq)
	);

	portOutput #(.DATA_W(DATA_W)) uPortOutput (
		.clk(clk), .nRESET(nRESET), .wr(wr), .dataIn(dataIn), .rs(rs),
		.portAIn(portAIn), .portBIn(portBIn),
		.pb7(pb7), .pb7Mode(acr[acrT1Pb7]),
		.t1Count(t1Count), .t1Latch(t1Latch), .t2Count(t2Count),
		.ifr(ifr), .ier(ier), .nIrq(nIrq),
		.portAOut(portAOut), .portAOe(portAOe),
		.portBOut(portBOut), .portBOe(portBOe),
		.acr(acr), .pcr(pcr), .dataOut(dataOut)
	);

endmodule

`default_nettype wire

/* hw/viaPkg.sv */
/*
	Shared VIA definitions
	Register selects, interrupt flag bits, ACR and PCR field positions
*/
`default_nettype none

package viaPkg;

	// Register selects on rs, in address order
	typedef enum logic [3:0] {
		regOrb, regOra, regDdrb, regDdra,
		regT1cl, regT1ch, regT1ll, regT1lh,
		regT2cl, regT2ch, regSr, regAcr,
		regPcr, regIfr, regIer, regOraNh
	} regAddr;

	// Bits of the 7-bit flag and enable registers
	localparam logic [2:0] flagCa2 = 3'd0;
	localparam logic [2:0] flagCa1 = 3'd1;
	localparam logic [2:0] flagSr  = 3'd2;
	localparam logic [2:0] flagCb2 = 3'd3;
	localparam logic [2:0] flagCb1 = 3'd4;
	localparam logic [2:0] flagT2  = 3'd5;
	localparam logic [2:0] flagT1  = 3'd6;

	// ACR fields
	localparam logic [2:0] acrT2Count   = 3'd5;
	localparam logic [2:0] acrT1FreeRun = 3'd6;
	localparam logic [2:0] acrT1Pb7     = 3'd7;

	// PCR edge select, set means rising edge
	localparam logic [2:0] pcrCa1Pos = 3'd0;
	localparam logic [2:0] pcrCa2Pos = 3'd2;
	localparam logic [2:0] pcrCb1Pos = 3'd4;
	localparam logic [2:0] pcrCb2Pos = 3'd6;

	// Order of the lines into the edge detector
	localparam logic [2:0] lineCa1 = 3'd0;
	localparam logic [2:0] lineCa2 = 3'd1;
	localparam logic [2:0] lineCb1 = 3'd2;
	localparam logic [2:0] lineCb2 = 3'd3;
	localparam logic [2:0] linePb6 = 3'd4;

endpackage

`default_nettype wire

/* tb/viaChecker.sv */
/*
	VIA testbench checker
	Watches the DUT outputs, compares with expected values, keeps the counts
*/
`timescale 1ns/100ps
`default_nettype none

module viaChecker (
	input wire [7:0] dataOut,
	input wire [7:0] dataOe,
	input wire [7:0] portAOut,
	input wire [7:0] portAOe,
	input wire [7:0] portBOut,
	input wire [7:0] portBOe,
	input wire       nIrq
);

	int checks      = 0;
	int errors      = 0;
	int testErrors  = 0;
	int tests       = 0;
	int testsFailed = 0;

	task automatic compareValue(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			testErrors++;
			$display("FAIL %s: got 0x%02h expected 0x%02h", name, got, exp);
		end
	endtask

	// Read data must be driven during a read cycle
	task automatic checkReg(input string name, input logic [7:0] exp);
		compareValue({"dataOut ", name}, dataOut, exp);
		compareValue("dataOe", dataOe, 8'hff);
	endtask

	task automatic checkPins(input logic [7:0] expAOut, input logic [7:0] expAOe,
			input logic [7:0] expBOut, input logic [7:0] expBOe);
		compareValue("portAOut", portAOut, expAOut);
		compareValue("portAOe", portAOe, expAOe);
		compareValue("portBOut", portBOut, expBOut);
		compareValue("portBOe", portBOe, expBOe);
	endtask

	task automatic checkEnables(input logic [7:0] expAOe, input logic [7:0] expBOe,
			input logic [7:0] expDataOe);
		compareValue("portAOe", portAOe, expAOe);
		compareValue("portBOe", portBOe, expBOe);
		compareValue("dataOe", dataOe, expDataOe);
	endtask

	task automatic checkIrq(input logic exp);
		compareValue("nIrq", {7'd0, nIrq}, {7'd0, exp});
	endtask

	task automatic checkPb7(input logic exp);
		compareValue("portBOut[7]", {7'd0, portBOut[7]}, {7'd0, exp});
	endtask

	task automatic checkNumber(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			testErrors++;
			$display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic reportFailure(input string msg);
		errors++;
		testErrors++;
		$display("ERROR: %s", msg);
	endtask

	task automatic testDone(input string name);
		tests++;
		if (testErrors == 0) begin
			$display("test %0d %s: passed", tests, name);
		end else begin
			testsFailed++;
			$display("test %0d %s: failed with %0d errors", tests, name, testErrors);
		end
		testErrors = 0;
	endtask

	task automatic printSummary();
		$display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
			tests, tests - testsFailed, testsFailed, checks, errors);
	endtask

endmodule

`default_nettype wire

/* tb/viaTb.sv */
/*
	VIA testbench top
	Clock, reset, bus tasks, register model, stimulus and run limit
*/
`timescale 1ns/100ps
`default_nettype none

module viaTb import viaPkg::*;;

	localparam int N1 = 20;
	localparam int N2 = 10;
	localparam int K  = 5;
	localparam int M  = 8;

	// Rough clk cycles per test
	localparam int CYCLE_LIMIT = 100 + 400 + 300 + 200 + 300 + 800 + 500;

	logic       clk;
	logic       nRESET;
	logic       clkEn;
	logic       cs1;
	logic       nCs2;
	logic       rnw;
	logic [3:0] rs;
	logic [7:0] dataIn;
	logic       ca1;
	logic       ca2;
	logic       cb1;
	logic       cb2;
	logic [7:0] portAIn;
	logic [7:0] portBIn;
	logic [7:0] dataOut;
	logic [7:0] dataOe;
	logic [7:0] portAOut;
	logic [7:0] portAOe;
	logic [7:0] portBOut;
	logic [7:0] portBOe;
	logic       nIrq;

	// Register model
	logic [7:0] shOra;
	logic [7:0] shOrb;
	logic [7:0] shDdra;
	logic [7:0] shDdrb;
	logic [7:0] shAcr;
	logic [7:0] shPcr;
	logic [6:0] shIer;

	logic [31:0] rngState = 32'he26147cb;
	int          cycles   = 0;

	via6522 #(.DATA_W(8)) i_dut (
		.clk(clk), .nRESET(nRESET), .clkEn(clkEn),
		.cs1(cs1), .nCs2(nCs2), .rnw(rnw), .rs(rs), .dataIn(dataIn),
		.ca1(ca1), .ca2(ca2), .cb1(cb1), .cb2(cb2),
		.portAIn(portAIn), .portBIn(portBIn),
		.dataOut(dataOut), .dataOe(dataOe),
		.portAOut(portAOut), .portAOe(portAOe),
		.portBOut(portBOut), .portBOe(portBOe), .nIrq(nIrq)
	);

	viaChecker uChecker (
		.dataOut(dataOut), .dataOe(dataOe),
		.portAOut(portAOut), .portAOe(portAOe),
		.portBOut(portBOut), .portBOe(portBOe), .nIrq(nIrq)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles without finishing the tests", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Expected read value from the writes made so far
	function automatic logic [7:0] expectedRead(input regAddr addr);
		case (addr)
			regOra, regOraNh: return (shOra & shDdra) | (portAIn & ~shDdra);
			regOrb:           return (shOrb & shDdrb) | (portBIn & ~shDdrb);
			regDdra:          return shDdra;
			regDdrb:          return shDdrb;
			regAcr:           return shAcr;
			regPcr:           return shPcr;
			regIer:           return {1'b1, shIer};
			default:          return 8'h00;
		endcase
	endfunction

	function automatic int flagOfLine(input int idx);
		case (idx)
			0:       return flagCa1;
			1:       return flagCa2;
			2:       return flagCb1;
			default: return flagCb2;
		endcase
	endfunction

	// Move to the falling edge that starts the next clkEn cycle, bus released
	task automatic nextEnCycle();
		@(negedge clk);
		clkEn = ~clkEn;
		cs1   = 1'b0;
		nCs2  = 1'b1;
		rnw   = 1'b1;
		if (!clkEn) begin
			@(negedge clk);
			clkEn = 1'b1;
		end
	endtask

	task automatic idleCycles(input int n);
		repeat (n) nextEnCycle();
	endtask

	task automatic busWrite(input regAddr addr, input logic [7:0] data);
		nextEnCycle();
		cs1    = 1'b1;
		nCs2   = 1'b0;
		rnw    = 1'b0;
		rs     = addr;
		dataIn = data;
		case (addr)
			regOra, regOraNh: shOra = data;
			regOrb:           shOrb = data;
			regDdra:          shDdra = data;
			regDdrb:          shDdrb = data;
			regAcr:           shAcr = data;
			regPcr:           shPcr = data;
			regIer:           shIer = data[7] ? (shIer | data[6:0]) : (shIer & ~data[6:0]);
			default:          ;
		endcase
	endtask

	task automatic busReadValue(input regAddr addr, output logic [7:0] data);
		nextEnCycle();
		cs1  = 1'b1;
		nCs2 = 1'b0;
		rnw  = 1'b1;
		rs   = addr;
		#10;
		data = dataOut;
	endtask

	task automatic busRead(input regAddr addr, input string name, input logic [7:0] exp);
		logic [7:0] unused;
		busReadValue(addr, unused);
		uChecker.checkReg(name, exp);
	endtask

	task automatic setLine(input int idx, input logic v);
		case (idx)
			0:       ca1 = v;
			1:       ca2 = v;
			2:       cb1 = v;
			default: cb2 = v;
		endcase
	endtask

	// Bounded poll with an idle cycle before each read
	task automatic waitFlag(input int bitPos, output logic found);
		logic [7:0] v;
		found = 1'b0;
		for (int t = 0; t < 12 && !found; t++) begin
			idleCycles(1);
			busReadValue(regIfr, v);
			found = v[bitPos];
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [7:0]  v;
		logic        prevPb7;
		logic        found;
		int          toggles;
		int          lastToggle;

		nRESET  = 1'b0;
		clkEn   = 1'b0;
		cs1     = 1'b0;
		nCs2    = 1'b1;
		rnw     = 1'b1;
		rs      = 4'd0;
		dataIn  = 8'h00;
		ca1     = 1'b0;
		ca2     = 1'b0;
		cb1     = 1'b0;
		cb2     = 1'b0;
		portAIn = 8'h00;
		portBIn = 8'h00;
		shOra   = 8'h00;
		shOrb   = 8'h00;
		shDdra  = 8'h00;
		shDdrb  = 8'h00;
		shAcr   = 8'h00;
		shPcr   = 8'h00;
		shIer   = 7'h00;
		repeat (10) @(negedge clk);
		nRESET = 1'b1;

		// Reset values
		#10;
		uChecker.checkIrq(1'b1);
		uChecker.checkEnables(8'h00, 8'h00, 8'h00);
		busRead(regDdra, "DDRA", 8'h00);
		busRead(regDdrb, "DDRB", 8'h00);
		busRead(regAcr, "ACR", 8'h00);
		busRead(regPcr, "PCR", 8'h00);
		busRead(regIfr, "IFR", 8'h00);
		busRead(regIer, "IER", 8'h80);
		uChecker.testDone("reset defaults");

		// Random direction and output values
		for (int i = 0; i < 8; i++) begin
			rngState = xorshift32(rngState);
			r = rngState;
			busWrite(regDdra, r[7:0]);
			rngState = xorshift32(rngState);
			portAIn = rngState[7:0];
			portBIn = rngState[15:8];
			busWrite(regOra, r[15:8]);
			busWrite(regDdrb, r[23:16]);
			busWrite(regOrb, r[31:24]);
			idleCycles(1);
			#10;
			uChecker.checkPins(shOra, shDdra, shOrb, shDdrb);
			busRead(regOra, "ORA", expectedRead(regOra));
			busRead(regOrb, "ORB", expectedRead(regOrb));
			busRead(regOraNh, "ORA no handshake", expectedRead(regOraNh));
		end
		uChecker.testDone("port direction and data");

		// Timer 1 one-shot with PB7
		busWrite(regIfr, 8'h7f);
		busWrite(regAcr, 8'h80);
		busWrite(regT1cl, 8'(N1));
		busWrite(regT1ch, 8'h00);
		for (int i = 0; i < N1 - 2; i++) begin
			busRead(regT1cl, "T1CL", 8'(N1 - i));
			if (i == 0)
				uChecker.checkPb7(1'b0);
		end
		idleCycles(N1);
		#10;
		uChecker.checkPb7(1'b1);
		uChecker.checkIrq(1'b1);
		busRead(regIfr, "IFR", 8'h40);
		busWrite(regIer, 8'hc0);
		idleCycles(1);
		#10;
		uChecker.checkIrq(1'b0);
		busRead(regIfr, "IFR", 8'hc0);
		busRead(regIer, "IER", expectedRead(regIer));
		busReadValue(regT1cl, v);
		idleCycles(1);
		#10;
		uChecker.checkIrq(1'b1);
		idleCycles(N1 + 5);
		busRead(regIfr, "IFR", 8'h00);
		busWrite(regIer, 8'h40);
		uChecker.testDone("timer 1 one-shot");

		// Timer 1 free run, PB7 half period is N2+1 clkEn cycles
		busWrite(regAcr, 8'hc0);
		busWrite(regT1cl, 8'(N2));
		busWrite(regT1ch, 8'h00);
		prevPb7    = 1'b0;
		toggles    = 0;
		lastToggle = 0;
		for (int i = 1; i <= 3 * (N2 + 1) + 3; i++) begin
			nextEnCycle();
			#10;
			if (i == 1)
				uChecker.checkPb7(1'b0);
			if (portBOut[7] !== prevPb7) begin
				if (toggles > 0)
					uChecker.checkNumber("pb7 half period", i - lastToggle, N2 + 1);
				toggles++;
				lastToggle = i;
				prevPb7    = portBOut[7];
			end
		end
		uChecker.checkNumber("pb7 toggles", toggles, 3);
		busRead(regIfr, "IFR", 8'h40);
		busReadValue(regT1cl, v);
		busRead(regIfr, "IFR", 8'h00);
		idleCycles(N2 + 2);
		busRead(regIfr, "IFR", 8'h40);
		busWrite(regAcr, 8'h00);
		busWrite(regIfr, 8'h7f);
		uChecker.testDone("timer 1 free run");

		// Timer 2 pulse counting on PB6, then one-shot
		nextEnCycle();
		portBIn[6] = 1'b1;
		idleCycles(4);
		busWrite(regAcr, 8'h20);
		busWrite(regT2cl, 8'(K));
		busWrite(regT2ch, 8'h00);
		busWrite(regIfr, 8'h7f);
		for (int i = 1; i <= K; i++) begin
			nextEnCycle();
			portBIn[6] = 1'b0;
			idleCycles(3);
			portBIn[6] = 1'b1;
			idleCycles(3);
			if (i < K)
				busRead(regT2cl, "T2CL", 8'(K - i));
		end
		busRead(regIfr, "IFR", 8'h20);
		busRead(regT2cl, "T2CL", 8'h00);
		busRead(regIfr, "IFR", 8'h00);
		busWrite(regAcr, 8'h00);
		busWrite(regT2cl, 8'(M));
		busWrite(regT2ch, 8'h00);
		for (int i = 0; i < 3; i++)
			busRead(regT2cl, "T2CL", 8'(M - i));
		idleCycles(M + 2);
		busRead(regIfr, "IFR", 8'h20);
		busReadValue(regT2cl, v);
		busRead(regIfr, "IFR", 8'h00);
		uChecker.testDone("timer 2");

		// Control line edges under both polarities
		for (int p = 0; p < 2; p++) begin
			busWrite(regPcr, p ? 8'h55 : 8'h00);
			nextEnCycle();
			for (int l = 0; l < 4; l++)
				setLine(l, p[0]);
			idleCycles(6);
			busWrite(regIfr, 8'h7f);
			for (int l = 0; l < 4; l++) begin
				// Inactive edge first
				nextEnCycle();
				setLine(l, ~p[0]);
				idleCycles(6);
				busRead(regIfr, "IFR", 8'h00);
				nextEnCycle();
				setLine(l, p[0]);
				waitFlag(flagOfLine(l), found);
				if (!found)
					uChecker.reportFailure($sformatf("flag of line %0d never set", l));
				busRead(regIfr, "IFR", 8'(1 << flagOfLine(l)));
				case (l)
					0:       busReadValue(regOra, v);
					1:       busWrite(regIfr, 8'(1 << flagCa2));
					2:       busWrite(regOrb, shOrb);
					default: busWrite(regIfr, 8'(1 << flagCb2));
				endcase
				busRead(regIfr, "IFR", 8'h00);
			end
		end
		uChecker.testDone("control line edges");

		uChecker.printSummary();
		if (uChecker.errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hw/viaPkg.sv
hw/edgeDetect.sv
hw/busDecode.sv
hw/intervalTimer1.sv
hw/pulseTimer2.sv
hw/interruptCtrl.sv
hw/portOutput.sv
hw/via6522.sv
tb/viaChecker.sv
tb/viaTb.sv
